// File: common/mbc_pkg.sv
package mbc_pkg;

   // -------------------------------------------------------------------------
   // widths
   // -------------------------------------------------------------------------
   localparam int CPU_ADDR_W = 16;
   localparam int CPU_DATA_W = 8;
   localparam int ROM_BANK_W = 9;    // 512 banks on mbc5
   localparam int RAM_SEL_W  = 4;    // ram bank register, up to 16 banks
   localparam int ROM_ADDR_W = 23;   // 10 bit half-bank + 13 bit offset

   // decoded mapper kind
   typedef enum logic [2:0] {
      NONE = 3'd0,
      MBC1 = 3'd1,
      MBC2 = 3'd2,
      MBC3 = 3'd3,
      MBC5 = 3'd4
   } mbc_kind_e;

   // same cpu address, seen as 8k window or as rom window
   typedef union packed {
      struct packed {
         logic [2:0]            region;   // a15..a13
         logic [CPU_ADDR_W-4:0] offset;
      } win;
      struct packed {
         logic                  hi;       // a15 set means not rom
         logic                  upper;    // a14, switchable 16k half
         logic                  half;     // a13, 8k half of a bank
         logic [CPU_ADDR_W-4:0] offset;
      } rom;
   } cpu_addr_u;

   // register write targets and cart ram window, by a15..a13
   localparam logic [2:0] REG_RAM_EN   = 3'b000;   // 0000-1fff
   localparam logic [2:0] REG_ROM_BANK = 3'b001;   // 2000-3fff
   localparam logic [2:0] REG_RAM_BANK = 3'b010;   // 4000-5fff
   localparam logic [2:0] REG_MODE     = 3'b011;   // 6000-7fff
   localparam logic [2:0] REG_CRAM     = 3'b101;   // a000-bfff

   localparam logic [3:0] RAM_EN_KEY = 4'hA;

   // apb config offsets
   localparam logic [3:0] CFG_TYPE     = 4'h0;
   localparam logic [3:0] CFG_ROM_SIZE = 4'h4;
   localparam logic [3:0] CFG_RAM_SIZE = 4'h8;

   // -------------------------------------------------------------------------
   // header decode
   // -------------------------------------------------------------------------
   function automatic mbc_kind_e mbc_kind_of(input logic [7:0] cart_type);
      mbc_kind_e kind;
      if (cart_type inside {[8'h01:8'h03]})
         kind = MBC1;
      else if (cart_type inside {[8'h05:8'h06]})
         kind = MBC2;
      else if (cart_type inside {[8'h0F:8'h13]})
         kind = MBC3;
      else if (cart_type inside {[8'h19:8'h1E]})
         kind = MBC5;
      else
         kind = NONE;   // rom only, or a mapper not handled here
      return kind;
   endfunction

   // 2**(code+1) banks
   function automatic logic [ROM_BANK_W-1:0] rom_mask_of(input logic [7:0] size_code);
      if (size_code <= 8'h08)
         return ~({ROM_BANK_W{1'b1}} << (size_code[3:0] + 4'd1));
      return 9'h07F;   // odd sizes 52..54 and junk
   endfunction

   function automatic logic [RAM_SEL_W-1:0] ram_mask_of(input logic [7:0] size_code);
      case (size_code)
         8'h00, 8'h01, 8'h02: return 4'h0;   // none, 2k, 8k
         8'h03:               return 4'h3;   // 32k
         8'h05:               return 4'h7;   // 64k
         default:             return 4'hF;   // 128k
      endcase
   endfunction

endpackage

// File: common/mbc_access_if.sv
`timescale 1ns/1ps

// one cpu access plus the bank state it was issued under
interface mbc_access_if;
   logic                             valid;
   logic                             rd;
   logic                             wr;
   mbc_pkg::cpu_addr_u               addr;
   logic [mbc_pkg::CPU_DATA_W-1:0]   wdata;
   logic [mbc_pkg::ROM_BANK_W-1:0]   rom_bank;
   logic [mbc_pkg::RAM_SEL_W-1:0]    ram_bank;
   logic                             mode;     // mbc1 mode or mbc3 rtc select
   logic                             ram_en;

   // producing stage
   modport src (
      output valid, rd, wr, addr, wdata,
      output rom_bank, ram_bank, mode, ram_en
   );

   // consuming stage
   modport dst (
      input valid, rd, wr, addr, wdata,
      input rom_bank, ram_bank, mode, ram_en
   );

endinterface

// File: source/mbc_cart_config.sv
`timescale 1ns/1ps

module mbc_cart_config (
   input  logic                              clk_sys,
   input  logic                              reset,
   input  logic [3:0]                        paddr,
   input  logic                              psel,
   input  logic                              penable,
   input  logic                              pwrite,
   input  logic [7:0]                        pwdata,
   output logic [7:0]                        prdata,
   output logic                              pready,
   output logic                              pslverr,
   output mbc_pkg::mbc_kind_e                kind,
   output logic [mbc_pkg::ROM_BANK_W-1:0]    rom_mask,
   output logic [mbc_pkg::RAM_SEL_W-1:0]     ram_mask
);

   logic [7:0] cart_type;   // header byte 0x147
   logic [7:0] rom_size;    // header byte 0x148
   logic [7:0] ram_size;    // header byte 0x149
   logic       access;      // apb access phase
   logic       hit;         // offset decodes to a register

   assign access = psel & penable;
   assign hit    = (paddr == mbc_pkg::CFG_TYPE) ||
                   (paddr == mbc_pkg::CFG_ROM_SIZE) ||
                   (paddr == mbc_pkg::CFG_RAM_SIZE);

   always_ff @(posedge clk_sys) begin
      if (reset) begin
         cart_type <= 8'h00;
         rom_size  <= 8'h00;
         ram_size  <= 8'h00;
      end else if (access && pwrite) begin
         case (paddr)
            mbc_pkg::CFG_TYPE:     cart_type <= pwdata;
            mbc_pkg::CFG_ROM_SIZE: rom_size  <= pwdata;
            mbc_pkg::CFG_RAM_SIZE: ram_size  <= pwdata;
            default: ;   // unknown offset, write dropped
         endcase
      end
   end

   always_comb begin
      case (paddr)
         mbc_pkg::CFG_TYPE:     prdata = cart_type;
         mbc_pkg::CFG_ROM_SIZE: prdata = rom_size;
         mbc_pkg::CFG_RAM_SIZE: prdata = ram_size;
         default:               prdata = 8'h00;
      endcase
   end

   assign pready  = 1'b1;             // no wait states
   assign pslverr = access & ~hit;

   // raw codes stay in here
   assign kind     = mbc_pkg::mbc_kind_of(cart_type);
   assign rom_mask = mbc_pkg::rom_mask_of(rom_size);
   assign ram_mask = mbc_pkg::ram_mask_of(ram_size);

endmodule

// File: banking/mbc_bank_regs.sv
`timescale 1ns/1ps

module mbc_bank_regs (
   input  logic                              clk_sys,
   input  logic                              reset,
   input  logic                              ce_cpu,
   input  logic [mbc_pkg::CPU_ADDR_W-1:0]    cart_addr,
   input  logic                              cart_rd,
   input  logic                              cart_wr,
   input  logic [mbc_pkg::CPU_DATA_W-1:0]    cart_di,
   input  mbc_pkg::mbc_kind_e                kind,
   mbc_access_if.src                         acc
);

   mbc_pkg::cpu_addr_u                 addr;
   logic                               accept;
   logic                               reg_wr;
   logic                               bank_zero;   // significant rom bank bits all 0
   logic [mbc_pkg::ROM_BANK_W-1:0]     rom_bank, rom_bank_nx;
   logic [mbc_pkg::RAM_SEL_W-1:0]      ram_bank, ram_bank_nx;
   logic                               mode, mode_nx;   // mbc1 mode, or mbc3 rtc
   logic                               ram_en, ram_en_nx;

   assign addr   = cart_addr;
   assign accept = ce_cpu & (cart_rd | cart_wr);
   assign reg_wr = ce_cpu & cart_wr;

   always_comb begin
      case (kind)
         mbc_pkg::MBC1: bank_zero = (cart_di[4:0] == 5'd0);
         mbc_pkg::MBC2: bank_zero = (cart_di[3:0] == 4'd0);
         default:       bank_zero = (cart_di[6:0] == 7'd0);
      endcase
   end

   // -------------------------------------------------------------------------
   // register update by region
   // -------------------------------------------------------------------------
   always_comb begin
      rom_bank_nx = rom_bank;
      ram_bank_nx = ram_bank;
      mode_nx     = mode;
      ram_en_nx   = ram_en;
      if (reg_wr) begin
         case (addr.win.region)
            mbc_pkg::REG_RAM_EN:
               ram_en_nx = (cart_di[3:0] == mbc_pkg::RAM_EN_KEY);
            mbc_pkg::REG_ROM_BANK: begin
               if (kind == mbc_pkg::MBC5) begin
                  if (addr.win.offset[12])
                     rom_bank_nx[8] = cart_di[0];       // 3000-3fff
                  else
                     rom_bank_nx[7:0] = cart_di;        // 2000-2fff
               end else if (bank_zero) begin
                  rom_bank_nx = 9'd1;                   // bank 0 maps to 1
               end else begin
                  rom_bank_nx = {2'b00, cart_di[6:0]};
               end
            end
            mbc_pkg::REG_RAM_BANK: begin
               if (kind == mbc_pkg::MBC3 && cart_di[3]) begin
                  mode_nx = 1'b1;                       // rtc register select
               end else begin
                  if (kind == mbc_pkg::MBC3)
                     mode_nx = 1'b0;                    // back to ram
                  if (kind == mbc_pkg::MBC5)
                     ram_bank_nx = cart_di[3:0];
                  else
                     ram_bank_nx = {2'b00, cart_di[1:0]};
               end
            end
            mbc_pkg::REG_MODE: begin
               if (kind == mbc_pkg::MBC1)
                  mode_nx = cart_di[0];
            end
            default: ;   // ram window or above, no register
         endcase
      end
   end

   always_ff @(posedge clk_sys) begin
      if (reset) begin
         rom_bank  <= 9'd1;
         ram_bank  <= '0;
         mode      <= 1'b0;
         ram_en    <= 1'b0;
         acc.valid <= 1'b0;
      end else begin
         rom_bank  <= rom_bank_nx;
         ram_bank  <= ram_bank_nx;
         mode      <= mode_nx;
         ram_en    <= ram_en_nx;
         acc.valid <= accept;
      end
   end

   // access and snapshot after this access's own update
   always_ff @(posedge clk_sys) begin
      if (accept) begin
         acc.rd       <= cart_rd;
         acc.wr       <= cart_wr;
         acc.addr     <= addr;
         acc.wdata    <= cart_di;
         acc.rom_bank <= rom_bank_nx;
         acc.ram_bank <= ram_bank_nx;
         acc.mode     <= mode_nx;
         acc.ram_en   <= ram_en_nx;
      end
   end

endmodule

// File: banking/mbc_addr_map.sv
`timescale 1ns/1ps

module mbc_addr_map #(
   parameter int RAM_BANK_W = 4
) (
   input  logic                              clk_sys,
   input  logic                              reset,
   input  mbc_pkg::mbc_kind_e                kind,
   input  logic [mbc_pkg::ROM_BANK_W-1:0]    rom_mask,
   input  logic [mbc_pkg::RAM_SEL_W-1:0]     ram_mask,
   mbc_access_if.dst                         in_acc,
   mbc_access_if.src                         out_acc,
   output logic [mbc_pkg::ROM_ADDR_W-1:0]    rom_addr,
   output logic                              rom_rd
);

   // banks that exist in the built ram
   localparam logic [mbc_pkg::RAM_SEL_W-1:0] BANK_LIMIT =
      mbc_pkg::RAM_SEL_W'((1 << RAM_BANK_W) - 1);

   logic [mbc_pkg::ROM_BANK_W-1:0]     sel_bank;     // 0 in the fixed lower window
   logic [mbc_pkg::ROM_BANK_W-1:0]     rom_bank_m;
   logic [1:0]                         bank2;        // mbc1 upper bits
   logic [mbc_pkg::RAM_SEL_W-1:0]      ram_bank_m;
   logic [mbc_pkg::ROM_ADDR_W-1:0]     rom_addr_s;
   logic                               rom_rd_s;

   assign sel_bank = in_acc.addr.rom.upper ? in_acc.rom_bank : '0;
   // mode 0 keeps bank2 off the lower rom window and the ram window
   assign bank2    = in_acc.ram_bank[1:0] & {2{in_acc.addr.rom.upper | in_acc.mode}};

   always_comb begin
      case (kind)
         mbc_pkg::MBC1: rom_bank_m = {2'b00, bank2, sel_bank[4:0]} & rom_mask;
         mbc_pkg::MBC2: rom_bank_m = {5'd0, sel_bank[3:0]} & rom_mask;
         mbc_pkg::MBC3: rom_bank_m = {2'b00, sel_bank[6:0]} & rom_mask;
         mbc_pkg::MBC5: rom_bank_m = sel_bank & rom_mask;   // bank 0 allowed
         default:       rom_bank_m = {8'd0, in_acc.addr.rom.upper};   // linear 32k
      endcase
   end

   always_comb begin
      case (kind)
         mbc_pkg::MBC1: ram_bank_m = {2'b00, bank2};
         mbc_pkg::MBC3,
         mbc_pkg::MBC5: ram_bank_m = in_acc.ram_bank;
         default:       ram_bank_m = '0;
      endcase
      ram_bank_m = ram_bank_m & ram_mask & BANK_LIMIT;   // mirror small rams
   end

   always_ff @(posedge clk_sys) begin
      if (reset) begin
         out_acc.valid <= 1'b0;
         rom_rd_s      <= 1'b0;
         rom_rd        <= 1'b0;
      end else begin
         out_acc.valid <= in_acc.valid;
         rom_rd_s      <= in_acc.valid & in_acc.rd & ~in_acc.addr.rom.hi;
         rom_rd        <= rom_rd_s;   // lines up with the cart ram read
      end
   end

   always_ff @(posedge clk_sys) begin
      out_acc.rd       <= in_acc.rd;
      out_acc.wr       <= in_acc.wr;
      out_acc.addr     <= in_acc.addr;
      out_acc.wdata    <= in_acc.wdata;
      out_acc.rom_bank <= rom_bank_m;
      out_acc.ram_bank <= ram_bank_m;
      out_acc.mode     <= in_acc.mode;
      out_acc.ram_en   <= in_acc.ram_en;
      rom_addr_s       <= {rom_bank_m, in_acc.addr.rom.half, in_acc.addr.rom.offset};
      rom_addr         <= rom_addr_s;
   end

endmodule

// File: source/mbc_cart_ram.sv
`timescale 1ns/1ps

module mbc_cart_ram #(
   parameter int RAM_BANK_W = 4
) (
   input  logic                              clk_sys,
   input  logic                              reset,
   input  mbc_pkg::mbc_kind_e                kind,
   mbc_access_if.dst                         in_acc,
   output logic [mbc_pkg::CPU_DATA_W-1:0]    cart_do,
   output logic                              cram_valid
);

   localparam int IDX_W = RAM_BANK_W + 13;   // bank + 8k offset

   logic [mbc_pkg::CPU_DATA_W-1:0]  mem [0:(2**IDX_W)-1];
   logic [IDX_W-1:0]                idx;
   logic                            is_cram;    // access hits a000-bfff
   logic [mbc_pkg::CPU_DATA_W-1:0]  ram_q;
   logic                            en_q;       // ram enabled at read time
   logic                            rtc_q;      // mbc3 rtc selected
   logic                            nib_q;      // mbc2 4 bit ram

   assign idx     = {in_acc.ram_bank[RAM_BANK_W-1:0], in_acc.addr.win.offset};
   assign is_cram = in_acc.valid && (in_acc.addr.win.region == mbc_pkg::REG_CRAM);

   // -------------------------------------------------------------------------
   // array and read flags
   // -------------------------------------------------------------------------
   always_ff @(posedge clk_sys) begin
      if (is_cram && in_acc.wr && in_acc.ram_en)
         mem[idx] <= in_acc.wdata;
      ram_q <= mem[idx];
      en_q  <= in_acc.ram_en;
      rtc_q <= (kind == mbc_pkg::MBC3) && in_acc.mode;
      nib_q <= (kind == mbc_pkg::MBC2);
   end

   always_ff @(posedge clk_sys) begin
      if (reset)
         cram_valid <= 1'b0;
      else
         cram_valid <= is_cram & in_acc.rd;
   end

   always_comb begin
      if (!en_q)
         cart_do = 8'hFF;                  // disabled ram floats high
      else if (nib_q)
         cart_do = {4'hF, ram_q[3:0]};     // only low nibble exists
      else if (rtc_q)
         cart_do = 8'h00;                  // no clock behind the rtc regs
      else
         cart_do = ram_q;
   end

endmodule

// File: source/mbc_mapper.sv
`timescale 1ns/1ps

module mbc_mapper #(
   parameter int RAM_BANK_W = 4   // cart ram holds 2**RAM_BANK_W banks of 8k
) (
   input  logic                                clk_sys,
   input  logic                                reset,
   input  logic                                ce_cpu,
   // cpu cartridge bus
   input  logic [mbc_pkg::CPU_ADDR_W-1:0]      cart_addr,
   input  logic                                cart_rd,
   input  logic                                cart_wr,
   input  logic [mbc_pkg::CPU_DATA_W-1:0]      cart_di,
   // apb config
   input  logic [3:0]                          paddr,
   input  logic                                psel,
   input  logic                                penable,
   input  logic                                pwrite,
   input  logic [7:0]                          pwdata,
   output logic [7:0]                          prdata,
   output logic                                pready,
   output logic                                pslverr,
   // results
   output logic [mbc_pkg::ROM_ADDR_W-1:0]      rom_addr,
   output logic                                rom_rd,
   output logic [mbc_pkg::CPU_DATA_W-1:0]      cart_do,
   output logic                                cram_valid
);

   mbc_pkg::mbc_kind_e                kind;
   logic [mbc_pkg::ROM_BANK_W-1:0]    rom_mask;
   logic [mbc_pkg::RAM_SEL_W-1:0]     ram_mask;

   mbc_access_if acc_map ();   // stage 1 -> 2
   mbc_access_if acc_ram ();   // stage 2 -> 3

   mbc_cart_config u_cart_config (
      .clk_sys  (clk_sys),
      .reset    (reset),
      .paddr    (paddr),
      .psel     (psel),
      .penable  (penable),
      .pwrite   (pwrite),
      .pwdata   (pwdata),
      .prdata   (prdata),
      .pready   (pready),
      .pslverr  (pslverr),
      .kind     (kind),
      .rom_mask (rom_mask),
      .ram_mask (ram_mask)
   );

   mbc_bank_regs u_bank_regs (
      .clk_sys   (clk_sys),
      .reset     (reset),
      .ce_cpu    (ce_cpu),
      .cart_addr (cart_addr),
      .cart_rd   (cart_rd),
      .cart_wr   (cart_wr),
      .cart_di   (cart_di),
      .kind      (kind),
      .acc       (acc_map.src)
   );

   mbc_addr_map #(.RAM_BANK_W(RAM_BANK_W)) u_addr_map (
      .clk_sys  (clk_sys),
      .reset    (reset),
      .kind     (kind),
      .rom_mask (rom_mask),
      .ram_mask (ram_mask),
      .in_acc   (acc_map.dst),
      .out_acc  (acc_ram.src),
      .rom_addr (rom_addr),
      .rom_rd   (rom_rd)
   );

   mbc_cart_ram #(.RAM_BANK_W(RAM_BANK_W)) u_cart_ram (
      .clk_sys    (clk_sys),
      .reset      (reset),
      .kind       (kind),
      .in_acc     (acc_ram.dst),
      .cart_do    (cart_do),
      .cram_valid (cram_valid)
   );

endmodule

// File: dv/tb_mbc_model.svh
// ----------------------------------------------------------------------------
// random source
// ----------------------------------------------------------------------------
logic [15:0] lfsr_state = 16'd26258;

function automatic logic [15:0] lfsr_next(input logic [15:0] s);
   return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);   // galois, taps 16 14 13 11
endfunction

function automatic logic [31:0] rand_bits(input int n);
   logic [31:0] v;
   v = '0;
   for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};   // one step per bit
      lfsr_state = lfsr_next(lfsr_state);
   end
   return v;
endfunction

// ----------------------------------------------------------------------------
// shadow state
// ----------------------------------------------------------------------------
mbc_pkg::mbc_kind_e tb_kind     = mbc_pkg::NONE;
logic [8:0]         tb_rom_mask = 9'h001;
logic [3:0]         tb_ram_mask = 4'h0;
logic [8:0]         sh_rom_bank = 9'd1;   // reset value
logic [3:0]         sh_ram_bank = 4'd0;
logic               sh_mode     = 1'b0;   // mbc1 mode or mbc3 rtc
logic               sh_ram_en   = 1'b0;
logic [7:0]         sh_ram [0:131071];    // 16 banks of 8k, unwritten bytes stay x

function automatic mbc_pkg::mbc_kind_e kind_from_type(input logic [7:0] t);
   if (t >= 8'h01 && t <= 8'h03) return mbc_pkg::MBC1;
   if (t == 8'h05 || t == 8'h06) return mbc_pkg::MBC2;
   if (t >= 8'h0F && t <= 8'h13) return mbc_pkg::MBC3;
   if (t >= 8'h19 && t <= 8'h1E) return mbc_pkg::MBC5;
   return mbc_pkg::NONE;
endfunction

function automatic logic [8:0] rom_mask_ref(input logic [7:0] code);
   if (code > 8'h08)
      return 9'h07F;
   return 9'((32'd1 << (code + 1)) - 1);
endfunction

function automatic logic [3:0] ram_mask_ref(input logic [7:0] code);
   if (code <= 8'h02) return 4'h0;
   if (code == 8'h03) return 4'h3;
   if (code == 8'h05) return 4'h7;
   return 4'hF;
endfunction

// cart ram byte index from the current banks
function automatic int cram_index(input logic [15:0] a);
   logic [3:0] b;
   case (tb_kind)
      mbc_pkg::MBC1: b = sh_mode ? {2'b00, sh_ram_bank[1:0]} : 4'd0;
      mbc_pkg::MBC3, mbc_pkg::MBC5: b = sh_ram_bank;
      default: b = 4'd0;
   endcase
   b = b & tb_ram_mask;
   return {b, a[12:0]};
endfunction

function automatic void model_write(input logic [15:0] a, input logic [7:0] d);
   logic z;
   case (a[15:13])
      3'b000: sh_ram_en = (d[3:0] == 4'hA);
      3'b001: begin
         if (tb_kind == mbc_pkg::MBC5) begin
            if (a[12]) sh_rom_bank[8] = d[0];
            else       sh_rom_bank[7:0] = d;
         end else begin
            z = (tb_kind == mbc_pkg::MBC1) ? (d[4:0] == 0) :
                (tb_kind == mbc_pkg::MBC2) ? (d[3:0] == 0) : (d[6:0] == 0);
            sh_rom_bank = z ? 9'd1 : {2'b00, d[6:0]};
         end
      end
      3'b010: begin
         if (tb_kind == mbc_pkg::MBC3 && d[3]) begin
            sh_mode = 1'b1;
         end else begin
            if (tb_kind == mbc_pkg::MBC3) sh_mode = 1'b0;
            sh_ram_bank = (tb_kind == mbc_pkg::MBC5) ? d[3:0] : {2'b00, d[1:0]};
         end
      end
      3'b011: if (tb_kind == mbc_pkg::MBC1) sh_mode = d[0];
      3'b101: if (sh_ram_en) sh_ram[cram_index(a)] = d;
      default: ;
   endcase
endfunction

function automatic logic [22:0] exp_rom_addr(input logic [15:0] a);
   logic [8:0] sel;
   logic [8:0] bank;
   logic [1:0] hi2;
   sel = a[14] ? sh_rom_bank : 9'd0;
   hi2 = (a[14] | sh_mode) ? sh_ram_bank[1:0] : 2'b00;
   case (tb_kind)
      mbc_pkg::MBC1: bank = {2'b00, hi2, sel[4:0]} & tb_rom_mask;
      mbc_pkg::MBC2: bank = {5'd0, sel[3:0]} & tb_rom_mask;
      mbc_pkg::MBC3: bank = {2'b00, sel[6:0]} & tb_rom_mask;
      mbc_pkg::MBC5: bank = sel & tb_rom_mask;
      default:       bank = {8'd0, a[14]};   // plain 32k
   endcase
   return {bank, a[13], a[12:0]};
endfunction

function automatic logic [7:0] exp_cram_data(input logic [15:0] a);
   logic [7:0] v;
   v = sh_ram[cram_index(a)];
   if (!sh_ram_en) return 8'hFF;
   if (tb_kind == mbc_pkg::MBC2) return {4'hF, v[3:0]};
   if (tb_kind == mbc_pkg::MBC3 && sh_mode) return 8'h00;
   return v;
endfunction

// File: dv/tb_mbc_mapper.sv
`timescale 1ns/1ps

module tb_mbc_mapper;

   logic        clk_sys = 1'b0;
   logic        reset, ce_cpu, cart_rd, cart_wr;
   logic [15:0] cart_addr;
   logic [7:0]  cart_di;
   logic [3:0]  paddr;
   logic        psel, penable, pwrite;
   logic [7:0]  pwdata, prdata;
   logic        pready, pslverr;
   logic [mbc_pkg::ROM_ADDR_W-1:0] rom_addr;
   logic        rom_rd, cram_valid;
   logic [mbc_pkg::CPU_DATA_W-1:0] cart_do;

   int cycle = 0;
   int err_mismatch = 0, err_missing = 0, err_other = 0;
   bit          exp_is_rom [$];   // pending reads, oldest first
   logic [22:0] exp_val [$];
   int          exp_due [$];      // cycle count at the strobe sample

   `include "tb_mbc_model.svh"

   mbc_mapper #(.RAM_BANK_W(4)) u_mbc_mapper (.*);

   always #10 clk_sys = ~clk_sys;
   always @(posedge clk_sys) cycle <= cycle + 1;

   task automatic check_rom_addr(input logic [mbc_pkg::ROM_ADDR_W-1:0] e, a);
      if (a !== e) begin
         $display("Mismatch rom_addr expected 0x%h actual 0x%h", e, a);
         err_mismatch++;
      end
   endtask

   task automatic check_cram_data(input logic [mbc_pkg::CPU_DATA_W-1:0] e, a);
      if (a !== e) begin
         $display("Mismatch cart_do expected 0x%h actual 0x%h", e, a);
         err_mismatch++;
      end
   endtask

   task automatic check_apb_data(input string name, input logic [7:0] e, a);
      if (a !== e) begin
         $display("Mismatch %s expected 0x%h actual 0x%h", name, e, a);
         err_mismatch++;
      end
   endtask

   // ------------------------------------------------------------------------
   // compare process, samples on the falling edge
   // ------------------------------------------------------------------------
   always @(negedge clk_sys) begin
      if (!reset) begin
         while (exp_due.size() > 0 && exp_due[0] < cycle) begin
            $display("no strobe for the read due at cycle %0d", exp_due[0]);
            err_missing++;
            void'(exp_is_rom.pop_front());
            void'(exp_val.pop_front());
            void'(exp_due.pop_front());
         end
         if (rom_rd || cram_valid) begin
            if (exp_due.size() == 0) begin
               $display("strobe at cycle %0d with no read pending", cycle);
               err_other++;
            end else begin
               if (exp_due[0] != cycle) begin
                  $display("strobe came early at cycle %0d, due %0d", cycle, exp_due[0]);
                  err_other++;
               end
               if (rom_rd && exp_is_rom[0])
                  check_rom_addr(exp_val[0], rom_addr);
               else if (cram_valid && !exp_is_rom[0])
                  check_cram_data(exp_val[0][7:0], cart_do);
               else begin
                  $display("wrong strobe kind at cycle %0d", cycle);
                  err_other++;
               end
               void'(exp_is_rom.pop_front());
               void'(exp_val.pop_front());
               void'(exp_due.pop_front());
            end
         end
      end
   end

   // ------------------------------------------------------------------------
   // bus tasks
   // ------------------------------------------------------------------------
   task automatic cpu_read(input logic [15:0] a);
      @(negedge clk_sys);
      ce_cpu = 1;
      cart_rd = 1;
      cart_wr = 0;
      cart_addr = a;
      if (!a[15] || a[15:13] == 3'b101) begin
         exp_is_rom.push_back(!a[15]);
         exp_val.push_back(a[15] ? {15'd0, exp_cram_data(a)} : exp_rom_addr(a));
         exp_due.push_back(cycle + 3);   // edge N+2, sampled on the next fall
      end
   endtask

   task automatic cpu_write(input logic [15:0] a, input logic [7:0] d);
      @(negedge clk_sys);
      ce_cpu = 1;
      cart_rd = 0;
      cart_wr = 1;
      cart_addr = a;
      cart_di = d;
      model_write(a, d);
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      @(negedge clk_sys);
      ce_cpu = 0;
      cart_rd = 0;
      cart_wr = 0;
      while (exp_due.size() > 0 && n < 20) begin
         @(negedge clk_sys);
         n++;
      end
      if (exp_due.size() > 0) begin
         $display("timeout waiting for %0d read strobes", exp_due.size());
         err_other++;
      end
   endtask

   task automatic apb_access(input logic [3:0] a, input logic wr, input logic [7:0] d,
                             output logic [7:0] rd, output logic err);
      int n;
      n = 0;
      @(negedge clk_sys);
      psel = 1;
      penable = 0;
      pwrite = wr;
      paddr = a;
      pwdata = d;
      @(negedge clk_sys);
      penable = 1;
      #5;
      while (!pready && n < 10) begin
         @(negedge clk_sys);
         #5;
         n++;
      end
      if (!pready) begin
         $display("timeout waiting for pready");
         err_other++;
      end
      rd = prdata;
      err = pslverr;
      @(negedge clk_sys);
      psel = 0;
      penable = 0;
      pwrite = 0;
   endtask

   task automatic set_cart(input logic [7:0] t, rs, ms);
      logic [7:0] rd;
      logic       err;
      apb_access(mbc_pkg::CFG_TYPE, 1'b1, t, rd, err);
      apb_access(mbc_pkg::CFG_ROM_SIZE, 1'b1, rs, rd, err);
      apb_access(mbc_pkg::CFG_RAM_SIZE, 1'b1, ms, rd, err);
      tb_kind = kind_from_type(t);
      tb_rom_mask = rom_mask_ref(rs);
      tb_ram_mask = ram_mask_ref(ms);
   endtask

   // ------------------------------------------------------------------------
   // stimulus
   // ------------------------------------------------------------------------
   initial begin
      logic [7:0]  rd, d;
      logic        err;
      logic [15:0] a;
      logic [16:0] wa [$];   // ram bank and 8k offset of each random write
      reset = 1;
      ce_cpu = 0;
      cart_rd = 0;
      cart_wr = 0;
      cart_addr = '0;
      cart_di = '0;
      paddr = '0;
      psel = 0;
      penable = 0;
      pwrite = 0;
      pwdata = '0;
      repeat (2) @(posedge clk_sys);
      @(negedge clk_sys);
      reset = 0;

      // apb config and linear map, type 08 is rom plus ram without mapper
      set_cart(8'h08, 8'h05, 8'h03);
      apb_access(mbc_pkg::CFG_TYPE, 1'b0, 8'h00, rd, err);
      check_apb_data("prdata", 8'h08, rd);
      apb_access(mbc_pkg::CFG_ROM_SIZE, 1'b0, 8'h00, rd, err);
      check_apb_data("prdata", 8'h05, rd);
      apb_access(mbc_pkg::CFG_RAM_SIZE, 1'b0, 8'h00, rd, err);
      check_apb_data("prdata", 8'h03, rd);
      apb_access(4'hC, 1'b1, 8'h77, rd, err);
      check_apb_data("pslverr", 8'h01, {7'd0, err});
      apb_access(4'hC, 1'b0, 8'h00, rd, err);
      check_apb_data("prdata", 8'h00, rd);
      check_apb_data("pslverr", 8'h01, {7'd0, err});
      apb_access(mbc_pkg::CFG_TYPE, 1'b0, 8'h00, rd, err);
      check_apb_data("pslverr", 8'h00, {7'd0, err});
      cpu_read(16'h0123);
      cpu_read(16'h4567);
      cpu_read(16'h7FFF);
      wait_drain();

      // mbc1 banking, mirroring, mode 1
      set_cart(8'h01, 8'h06, 8'h03);
      cpu_write(16'h2000, 8'h00);
      cpu_read(16'h4000);   // bank 0 gives 1
      for (int i = 0; i < 8; i++) begin
         cpu_write(16'h2000, 8'(rand_bits(5)));
         cpu_write(16'h4000, 8'(rand_bits(2)));
         cpu_read({2'b01, 14'(rand_bits(14))});
      end
      wait_drain();
      set_cart(8'h01, 8'h02, 8'h03);
      cpu_write(16'h2000, 8'h1D);
      cpu_read(16'h4000);   // mirrors to 5
      wait_drain();
      set_cart(8'h01, 8'h06, 8'h03);
      cpu_write(16'h6000, 8'h01);
      cpu_write(16'h4000, 8'h02);
      cpu_read(16'h0100);
      cpu_write(16'h6000, 8'h00);
      cpu_read(16'h0100);
      wait_drain();

      // mbc5 nine bit bank
      set_cart(8'h19, 8'h08, 8'h04);
      cpu_write(16'h2000, 8'hA5);
      cpu_write(16'h3000, 8'h01);
      cpu_read(16'h4000);
      cpu_write(16'h2000, 8'h00);
      cpu_write(16'h3000, 8'h00);
      cpu_read(16'h5000);
      for (int i = 0; i < 6; i++) begin
         cpu_write(16'h2000, 8'(rand_bits(8)));
         cpu_write(16'h3000, 8'(rand_bits(1)));
         cpu_read({2'b01, 14'(rand_bits(14))});
      end
      wait_drain();

      // cart ram enable and banks
      cpu_write(16'h0000, 8'h00);
      cpu_read(16'hA000);   // disabled reads ff
      cpu_write(16'h0000, 8'h0A);
      cpu_write(16'hA020, 8'h11);
      cpu_write(16'h0000, 8'h00);
      cpu_write(16'hA020, 8'h99);
      cpu_read(16'hA020);
      cpu_write(16'h0000, 8'h0A);
      cpu_read(16'hA020);
      for (int i = 0; i < 12; i++) begin
         a = {3'b101, 13'(rand_bits(13))};
         d = 8'(rand_bits(4));
         cpu_write(16'h4000, d);
         cpu_write(a, 8'(rand_bits(8)));
         wa.push_back({d[3:0], a[12:0]});
      end
      foreach (wa[i]) begin
         cpu_write(16'h4000, {4'h0, wa[i][16:13]});
         cpu_read({3'b101, wa[i][12:0]});
      end
      wait_drain();
      set_cart(8'h19, 8'h08, 8'h03);   // two bank bits left
      cpu_write(16'h4000, 8'h06);
      cpu_write(16'hA100, 8'h77);
      cpu_write(16'h4000, 8'h02);
      cpu_read(16'hA100);
      wait_drain();

      // mbc2 nibble ram, mbc3 rtc select
      set_cart(8'h05, 8'h03, 8'h00);
      cpu_write(16'hA005, 8'hC3);
      cpu_read(16'hA005);
      wait_drain();
      set_cart(8'h0F, 8'h06, 8'h03);
      cpu_write(16'h4000, 8'h01);
      cpu_write(16'hA007, 8'h5A);
      cpu_write(16'h4000, 8'h08);
      cpu_read(16'hA007);
      cpu_write(16'h4000, 8'h01);
      cpu_read(16'hA007);
      wait_drain();

      // back to back reads
      cpu_read(16'h4ABC);
      cpu_read(16'hA007);
      cpu_read(16'h1234);
      cpu_read(16'h6321);
      wait_drain();

      $display("errors: mismatch %0d, missing %0d, other %0d",
               err_mismatch, err_missing, err_other);
      if (err_mismatch + err_missing + err_other == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule

// File: mbc_mapper.f
+incdir+dv
common/mbc_pkg.sv
common/mbc_access_if.sv
source/mbc_cart_config.sv
banking/mbc_bank_regs.sv
banking/mbc_addr_map.sv
source/mbc_cart_ram.sv
source/mbc_mapper.sv
dv/tb_mbc_mapper.sv

// File: Bender.yml
package:
  name: mbc_mapper

sources:
  - common/mbc_pkg.sv
  - common/mbc_access_if.sv
  - source/mbc_cart_config.sv
  - banking/mbc_bank_regs.sv
  - banking/mbc_addr_map.sv
  - source/mbc_cart_ram.sv
  - source/mbc_mapper.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/tb_mbc_mapper.sv
